//--- test/tx_mac_testdata.txt
// Record: buffer word address, length in octets, payload octets, expected FCS
// All values in hex, and a record with length 0 ends the list
000 001 61 e8b7be43
010 003 61 62 63 352441c2
3e0 03e
41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a
61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a
30 31 32 33 34 35 36 37 38 39
1fc2e6d2
020 009 31 32 33 34 35 36 37 38 39 cbf43926
200 02b
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20 6a 75
6d 70 73 20 6f 76 65 72 20 74 68 65 20 6c 61 7a 79 20 64 6f 67
414fa339
100 00e 6d 65 73 73 61 67 65 20 64 69 67 65 73 74 20159d7f
080 01a
61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a
4c2750bd
000 000

//--- tx_mac.f
hw/tx_mac_pkg.sv
hw/tx_octet_if.sv
hw/tx_buffer_ram.sv
hw/tx_packet_reader.sv
hw/crc32_octet.sv
hw/tx_framer.sv
hw/tx_mac_top.sv
test/tx_mac_checker.sv
test/tb_tx_mac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and judges the run from its log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -j 0 --top-module tb_tx_mac -f tx_mac.f -o tb_tx_mac \
	&& ./obj_dir/tb_tx_mac > "$LOG" 2>&1 \
	|| echo "Simulation failed" >> "$LOG"
cat "$LOG"
! grep -q "Simulation failed" "$LOG" \
	&& grep -q "Simulation completed successfully" "$LOG" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- test/tb_tx_mac.sv
`timescale 1ns/1ps

// Testbench top for the transmit path.
// Every packet of the data file is loaded into the buffer first, so each one
// has to be read back from its own address when it is started
module tb_tx_mac;

	import tx_mac_pkg::*;

	localparam int DATA_WORDS = 1024;

	logic clk;
	logic reset;
	logic host_we;
	logic [MAC_AW-1:0] host_waddr;
	logic [15:0] host_wdata;
	logic start;
	logic [MAC_AW-1:0] buf_start_addr;
	logic done;
	logic tx_valid;
	logic [7:0] tx_data;

	// Flat copy of the data file, one record after another
	logic [31:0] records [DATA_WORDS];
	int limit_cycles;
	bit limit_ready;
	int checked_errors;
	bit checker_finished;

	tx_mac_top i_tx_mac_top (
		.clk(clk),
		.reset(reset),
		.host_we(host_we),
		.host_waddr(host_waddr),
		.host_wdata(host_wdata),
		.start(start),
		.buf_start_addr(buf_start_addr),
		.done(done),
		.tx_valid(tx_valid),
		.tx_data(tx_data)
	);

	tx_mac_checker i_tx_mac_checker (
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.errors(checked_errors),
		.finished(checker_finished)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// One host write, set up on the falling edge and taken on the rising one
	task automatic write_word(input int addr, input logic [15:0] word);
		@(negedge clk);
		host_we = 1'b1;
		host_waddr = MAC_AW'(addr);
		host_wdata = word;
	endtask

	// Length word first, then the payload with the earlier octet in the low half
	task automatic load_packet(input int p);
		int len;
		int addr;
		logic [7:0] lo;
		logic [7:0] hi;
		len = int'(records[p+1]);
		addr = int'(records[p]);
		write_word(addr, 16'(len));
		for (int k = 0; k < (len + 1) / 2; k++) begin
			lo = records[p+2+2*k][7:0];
			// An odd length leaves the top half of the last word unused
			hi = (2 * k + 1 < len) ? records[p+3+2*k][7:0] : 8'h00;
			write_word(addr + 1 + k, {hi, lo});
		end
	endtask

	// Four-phase start and done exchange for one packet
	task automatic send_packet(input int addr);
		@(negedge clk);
		start = 1'b1;
		buf_start_addr = MAC_AW'(addr);
		while (!done) @(negedge clk);
		start = 1'b0;
		while (done) @(negedge clk);
	endtask

	// Frame time plus slack for loading and the random pauses
	function automatic int run_budget();
		int p;
		int n;
		int total;
		p = 0;
		n = 0;
		total = 0;
		while (records[p+1] != 32'h0) begin
			total = total + int'(records[p+1]) + 40;
			n++;
			p = p + int'(records[p+1]) + 3;
		end
		return total + 40 * n + 200;
	endfunction

	initial begin
		int p;
		int idle;
		host_we = 1'b0;
		host_waddr = '0;
		host_wdata = '0;
		start = 1'b0;
		buf_start_addr = '0;
		reset = 1'b1;
		void'($urandom(57513));
		$readmemh("test/tx_mac_testdata.txt", records);
		limit_cycles = run_budget();
		limit_ready = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Fill the buffer with every packet before any is sent
		p = 0;
		while (records[p+1] != 32'h0) begin
			load_packet(p);
			p = p + int'(records[p+1]) + 3;
		end
		@(negedge clk);
		host_we = 1'b0;

		p = 0;
		while (records[p+1] != 32'h0) begin
			idle = int'($urandom_range(0, 20));
			repeat (idle) @(negedge clk);
			send_packet(int'(records[p]));
			p = p + int'(records[p+1]) + 3;
		end

		// The last frame is still on the line when its done has fallen
		wait (checker_finished);
		@(posedge clk);
		if (checked_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clk);
		$display("Watchdog: no result after %0d cycles, the run timed out", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- test/tx_mac_checker.sv
`timescale 1ns/1ps

// Watches the octet stream and the host handshake.
// Each burst of tx_valid is matched against the next record of the data file
module tx_mac_checker (
	input logic clk,
	input logic reset,
	input logic start,
	input logic done,
	input logic tx_valid,
	input logic [7:0] tx_data,
	output int errors,
	output bit finished
);

	localparam int GAP_MIN = 12;
	localparam int HEAD_LEN = 8;

	logic [31:0] records [1024];
	int rec_ptr;
	int frame_num;
	int pos;
	int idle_run;
	int frame_errors;
	int passed;
	int failed;
	bit done_seen;
	logic done_d;
	logic start_d;

	initial begin
		$readmemh("test/tx_mac_testdata.txt", records);
	end

	// Seven preamble octets, the delimiter, the payload, then the FCS low octet first
	function automatic logic [7:0] expected_octet(input int p, input int i);
		int len;
		len = int'(records[p+1]);
		if (i < HEAD_LEN - 1) return 8'h55;
		if (i == HEAD_LEN - 1) return 8'hD5;
		if (i < HEAD_LEN + len) return records[p+2+i-HEAD_LEN][7:0];
		return records[p+2+len][8*(i-HEAD_LEN-len) +: 8];
	endfunction

	// Length check, verdict line, and a step to the next record
	task automatic close_frame(input int len);
		if (pos != HEAD_LEN + len + 4) begin
			$display("Frame %0d had %0d valid cycles instead of %0d", frame_num, pos,
				HEAD_LEN + len + 4);
			frame_errors++;
		end
		if (!done_seen) begin
			$display("Frame %0d ended without done rising", frame_num);
			frame_errors++;
		end
		if (frame_errors == 0) begin
			passed++;
			$display("Packet %0d at 0x%03h, %0d octets: PASS", frame_num,
				records[rec_ptr][9:0], len);
		end else begin
			failed++;
			$display("Packet %0d at 0x%03h, %0d octets: FAIL with %0d errors", frame_num,
				records[rec_ptr][9:0], len, frame_errors);
		end
		errors = errors + frame_errors;
		frame_errors = 0;
		done_seen = 1'b0;
		pos = 0;
		frame_num++;
		rec_ptr = rec_ptr + len + 3;
		// A zero length marks the end of the list
		if (records[rec_ptr+1] == 32'h0) begin
			$display("Checker totals: %0d packets, %0d passed, %0d failed, %0d errors",
				frame_num, passed, failed, errors);
			finished = 1'b1;
		end
	endtask

	always @(posedge clk) begin
		int len;
		logic [7:0] want;
		if (reset) begin
			rec_ptr = 0;
			frame_num = 0;
			pos = 0;
			idle_run = GAP_MIN;
			frame_errors = 0;
			passed = 0;
			failed = 0;
			errors = 0;
			done_seen = 1'b0;
			finished = 1'b0;
		end else if (!finished) begin
			len = int'(records[rec_ptr+1]);
			// The last strobe raises done as the last payload octet goes out
			if (done && !done_d) begin
				done_seen = 1'b1;
				if (!tx_valid || pos != HEAD_LEN + len - 1) begin
					$display("Frame %0d: done rose at octet %0d, not with the last payload octet",
						frame_num, pos);
					frame_errors++;
				end
			end
			if (!done && done_d && start_d) begin
				$display("Frame %0d: done fell while start was still high", frame_num);
				frame_errors++;
			end
			if (tx_valid) begin
				if (pos == 0 && idle_run < GAP_MIN) begin
					$display("Frame %0d began after only %0d idle cycles", frame_num, idle_run);
					frame_errors++;
				end
				if (pos < HEAD_LEN + len + 4) begin
					want = expected_octet(rec_ptr, pos);
					if (tx_data !== want) begin
						$display("ERR tx_data frame %0d octet %0d: got 0x%h, expected 0x%h",
							frame_num, pos, tx_data, want);
						frame_errors++;
					end
				end
				pos++;
				idle_run = 0;
			end else begin
				if (pos != 0) begin
					close_frame(len);
				end
				idle_run++;
			end
		end
		done_d = done;
		start_d = start;
	end

endmodule

//--- hw/tx_mac_top.sv
`timescale 1ns/1ps

// Transmit path from the host packet buffer to the octet stream.
// The host loads the RAM, then starts the reader with a 4-phase handshake
module tx_mac_top #(
	parameter int mac_aw = tx_mac_pkg::MAC_AW,
	parameter bit big_endian = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic host_we,
	input logic [mac_aw-1:0] host_waddr,
	input logic [15:0] host_wdata,
	input logic start,
	input logic [mac_aw-1:0] buf_start_addr,
	output logic done,
	output logic tx_valid,
	output logic [7:0] tx_data
);

	import tx_mac_pkg::*;

	logic [mac_aw-1:0] rd_addr;
	logic [15:0] rd_data;

	tx_octet_if #(.len_w(LEN_W)) oct ();

	tx_buffer_ram #(.mac_aw(mac_aw)) i_tx_buffer_ram (
		.clk(clk),
		.we(host_we),
		.waddr(host_waddr),
		.wdata(host_wdata),
		.raddr(rd_addr),
		.rdata(rd_data)
	);

	tx_packet_reader #(.mac_aw(mac_aw), .big_endian(big_endian)) i_tx_packet_reader (
		.clk(clk),
		.reset(reset),
		.start(start),
		.buf_start_addr(buf_start_addr),
		.host_d(rd_data),
		.host_addr(rd_addr),
		.done(done),
		.oct(oct.source)
	);

	tx_framer i_tx_framer (
		.clk(clk),
		.reset(reset),
		.oct(oct.sink),
		.tx_valid(tx_valid),
		.tx_data(tx_data)
	);

endmodule

//--- hw/tx_framer.sv
`timescale 1ns/1ps

// Builds the frame around the payload.
// The state names the kind of octet presently on tx_data, so the line sees
// preamble, delimiter, payload and FCS back to back, then the interframe gap
module tx_framer (
	input logic clk,
	input logic reset,
	tx_octet_if.sink oct,
	output logic tx_valid,
	output logic [7:0] tx_data
);

	import tx_mac_pkg::*;

	localparam int CNT_W = $clog2(IFG_LEN + 1);

	framer_state_t state;
	logic [CNT_W-1:0] cnt;
	logic [31:0] fcs;
	logic [31:0] fcs_sr;

	// Payload octets are taken one cycle ahead of their slot on the line.
	// The first goes while the delimiter is out, the rest while data is out
	// and the reader still has octets left
	assign oct.strobe = (state == FR_SFD) || (state == FR_DATA && oct.len_req != '0);

	crc32_octet i_crc32_octet (
		.clk(clk),
		.reset(reset),
		.init(state == FR_IDLE),
		.enable(oct.strobe),
		.data(oct.mac_data),
		.fcs(fcs)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FR_IDLE;
			cnt <= '0;
			tx_valid <= 1'b0;
		end else begin
			case (state)
				FR_IDLE: begin
					// No transmit arbitration here, so a request always starts a frame
					if (oct.req) begin
						state <= FR_PREAMBLE;
						tx_valid <= 1'b1;
						cnt <= '0;
					end
				end
				FR_PREAMBLE: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(PREAMBLE_LEN - 1)) begin
						state <= FR_SFD;
					end
				end
				FR_SFD: begin
					state <= FR_DATA;
				end
				FR_DATA: begin
					// Nothing taken this cycle means the last payload octet is out
					if (!oct.strobe) begin
						state <= FR_FCS;
						cnt <= '0;
					end
				end
				FR_FCS: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(3)) begin
						state <= FR_GAP;
						tx_valid <= 1'b0;
						cnt <= '0;
					end
				end
				FR_GAP: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(IFG_LEN - 1)) begin
						state <= FR_IDLE;
					end
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

	// Output octet for the next cycle, chosen from where the state goes next
	always_ff @(posedge clk) begin
		case (state)
			FR_IDLE: tx_data <= PREAMBLE_OCTET;
			FR_PREAMBLE: begin
				tx_data <= (cnt == CNT_W'(PREAMBLE_LEN - 1)) ? SFD_OCTET : PREAMBLE_OCTET;
			end
			FR_SFD: tx_data <= oct.mac_data;
			FR_DATA: begin
				if (oct.strobe) begin
					tx_data <= oct.mac_data;
				end else begin
					// CRC already holds the last octet, capture it whole
					tx_data <= fcs[7:0];
					fcs_sr <= fcs >> 8;
				end
			end
			FR_FCS: begin
				tx_data <= fcs_sr[7:0];
				fcs_sr <= fcs_sr >> 8;
			end
			default: tx_data <= 8'h00;
		endcase
	end

	// Nothing goes out between frames
	no_valid_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		state inside {FR_IDLE, FR_GAP} |-> !tx_valid
	);

	// The reader keeps its request up until the payload has been taken
	req_held_in_preamble: assert property (
		@(posedge clk) disable iff (reset)
		state == FR_PREAMBLE |-> oct.req
	);

endmodule

//--- hw/crc32_octet.sv
`timescale 1ns/1ps

// CRC-32 remainder for the frame check sequence, one octet per clock.
// Bits are folded in LSB first, as they go out on the wire
module crc32_octet (
	input logic clk,
	input logic reset,
	input logic init,
	input logic enable,
	input logic [7:0] data,
	output logic [31:0] fcs
);

	import tx_mac_pkg::*;

	logic [31:0] crc;

	// Eight serial steps of the reflected polynomial, unrolled
	function automatic logic [31:0] crc_step(input logic [31:0] crc_in, input logic [7:0] octet);
		logic [31:0] c;
		c = crc_in ^ {24'd0, octet};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY_REFLECTED) : (c >> 1);
		end
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (reset || init) begin
			crc <= CRC_INIT;
		end else if (enable) begin
			crc <= crc_step(crc, data);
		end
	end

	// The transmitted FCS is the ones complement of the remainder.
	// Its low octet goes out first
	assign fcs = ~crc;

endmodule

//--- hw/tx_packet_reader.sv
`timescale 1ns/1ps

// Walks one packet out of the buffer.
// The first word of the buffer holds the length in octets, and the payload
// follows two octets per word. Each strobe from the framer consumes one
// octet, and the word half is picked by the odd-octet flag and the endianness
module tx_packet_reader #(
	parameter int mac_aw = tx_mac_pkg::MAC_AW,
	parameter bit big_endian = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [mac_aw-1:0] buf_start_addr,
	input logic [15:0] host_d,
	output logic [mac_aw-1:0] host_addr,
	output logic done,
	tx_octet_if.source oct
);

	import tx_mac_pkg::*;

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_SKIP,
		RD_LOAD,
		RD_STREAM,
		RD_RELEASE
	} reader_mode_t;

	reader_mode_t mode;
	logic [mac_aw-1:0] buffer_point;
	logic [LEN_W-1:0] len_left;
	logic odd_octet;
	logic req_r;

	// From a new buffer_point it takes two edges before the word can be used.
	// One for the RAM read register and one to act on its output
	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= RD_IDLE;
			buffer_point <= '0;
			len_left <= '0;
			odd_octet <= 1'b0;
			req_r <= 1'b0;
			done <= 1'b0;
		end else begin
			case (mode)
				RD_IDLE: begin
					if (start) begin
						mode <= RD_SKIP;
						buffer_point <= buf_start_addr;
					end
				end
				RD_SKIP: begin
					// Length word is being read, so point at the first payload word
					mode <= RD_LOAD;
					buffer_point <= buffer_point + 1'b1;
				end
				RD_LOAD: begin
					mode <= RD_STREAM;
					len_left <= host_d[LEN_W-1:0];
					odd_octet <= 1'b0;
					req_r <= 1'b1;
				end
				RD_STREAM: begin
					if (oct.strobe) begin
						odd_octet <= ~odd_octet;
						// Step to the next word once the low half has gone, the RAM
						// then has the new word ready by the time it is needed
						if (!odd_octet) begin
							buffer_point <= buffer_point + 1'b1;
						end
						len_left <= len_left - 1'b1;
						if (len_left == LEN_W'(1)) begin
							mode <= RD_RELEASE;
							req_r <= 1'b0;
							done <= 1'b1;
						end
					end
				end
				RD_RELEASE: begin
					// Hold done until the host lets go of start
					if (!start) begin
						mode <= RD_IDLE;
						done <= 1'b0;
					end
				end
				default: mode <= RD_IDLE;
			endcase
		end
	end

	assign host_addr = buffer_point;
	assign oct.req = req_r;
	assign oct.len_req = len_left;
	assign oct.mac_data = (odd_octet ^ big_endian) ? host_d[15:8] : host_d[7:0];

	// The framer may only take octets while a packet is being streamed
	strobe_in_stream: assert property (
		@(posedge clk) disable iff (reset)
		oct.strobe |-> mode == RD_STREAM
	);

	// An empty packet would leave req up with nothing behind it
	length_nonzero: assert property (
		@(posedge clk) disable iff (reset)
		mode == RD_LOAD |-> host_d[LEN_W-1:0] != '0
	);

endmodule

//--- hw/tx_buffer_ram.sv
`timescale 1ns/1ps

// Packet buffer shared between the host and the transmit path.
// The host fills it through the write port, and the reader walks it
// through the read port, which has one cycle of latency
module tx_buffer_ram #(
	parameter int mac_aw = tx_mac_pkg::MAC_AW
) (
	input logic clk,
	input logic we,
	input logic [mac_aw-1:0] waddr,
	input logic [15:0] wdata,
	input logic [mac_aw-1:0] raddr,
	output logic [15:0] rdata
);

	localparam int DEPTH = 1 << mac_aw;

	logic [15:0] mem [DEPTH];

	// Host side write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, so the word shows up the cycle after its address.
	// A write and a read of the same word in one cycle return the old word
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- hw/tx_octet_if.sv
`timescale 1ns/1ps

// Octet stream between the packet reader and the framer.
// The reader holds req for the whole packet and presents the current octet
// on mac_data, and the framer takes it with a single-cycle strobe
interface tx_octet_if #(
	parameter int len_w = tx_mac_pkg::LEN_W
);

	logic req;
	logic [len_w-1:0] len_req;
	logic strobe;
	logic [7:0] mac_data;

	// The reader owns the packet and its octets
	modport source (output req, output len_req, output mac_data, input strobe);

	// The framer decides when an octet is taken
	modport sink (input req, input len_req, input mac_data, output strobe);

endinterface

//--- hw/tx_mac_pkg.sv
package tx_mac_pkg;

	// Default word address width of the packet buffer, in 16-bit words
	localparam int MAC_AW = 10;

	// Octet length field, wide enough to describe one MTU
	localparam int LEN_W = 11;

	// Fixed octets that open every frame on the line
	localparam logic [7:0] PREAMBLE_OCTET = 8'h55;
	localparam logic [7:0] SFD_OCTET = 8'hD5;

	// Number of preamble octets sent ahead of the delimiter
	localparam int PREAMBLE_LEN = 7;

	// Idle cycles held on the line after the last FCS octet
	localparam int IFG_LEN = 12;

	// CRC-32 as used for the Ethernet frame check sequence, bit reversed
	localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;

	// Phase of the octet currently presented on the framer output
	typedef enum logic [2:0] {
		FR_IDLE,
		FR_PREAMBLE,
		FR_SFD,
		FR_DATA,
		FR_FCS,
		FR_GAP
	} framer_state_t;

endpackage
